//--- source/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// load queue
`define LB_COUNT 8
`define LB_PTR_W 3

// reorder buffer tag
`define ROB_W 4

// byte addressed data memory
`define ADDR_W 10
`define MEM_DEPTH 1024

`endif

//--- source/mem_pkg.sv
package mem_pkg;

	// one memory word, filled lane by lane, read back as halves or bytes
	typedef union packed {
		logic [3:0][7:0]  lane;
		logic [1:0][15:0] half;
	} mem_word_u;

	// bytes moved per access
	typedef logic [2:0] byte_cnt_t;

	localparam byte_cnt_t BYTES_B = 3'd1;
	localparam byte_cnt_t BYTES_H = 3'd2;
	localparam byte_cnt_t BYTES_W = 3'd4;

endpackage : mem_pkg

//--- source/load_pkg.sv
package load_pkg;
	import mem_pkg::*;

	// funct3 encoding of the RV32 loads
	typedef enum logic [2:0] {
		LB  = 3'b000,
		LH  = 3'b001,
		LW  = 3'b010,
		LBU = 3'b100,
		LHU = 3'b101
	} load_op_e;

	function automatic byte_cnt_t op_bytes(input load_op_e op);
		case (op)
			LB, LBU: return BYTES_B;
			LH, LHU: return BYTES_H;
			default: return BYTES_W;
		endcase
	endfunction

	// keep the low part of the word, then sign or zero extend
	function automatic logic [31:0] extend_load(input logic [31:0] word, input load_op_e op);
		mem_word_u w;
		w = word;
		case (op)
			LB:      return {{24{w.lane[0][7]}}, w.lane[0]};
			LH:      return {{16{w.half[0][15]}}, w.half[0]};
			LBU:     return {24'd0, w.lane[0]};
			LHU:     return {16'd0, w.half[0]};
			default: return w;
		endcase
	endfunction

endpackage : load_pkg

//--- source/byte_ram.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module byte_ram (
	input  logic               clk_in,

	// read port, data one cycle later
	input  logic               rd_en,
	input  logic [`ADDR_W-1:0] rd_addr,
	output logic [7:0]         rd_data,

	// preload port
	input  logic               wr_en,
	input  logic [`ADDR_W-1:0] wr_addr,
	input  logic [7:0]         wr_data
);

	logic [7:0] mem [`MEM_DEPTH];

	always_ff @(posedge clk_in) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_addr]; // old byte on a same-cycle write
	end

endmodule : byte_ram

//--- source/data_ctrl.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module data_ctrl
	import mem_pkg::*;
	import load_pkg::*;
(
	input  logic               clk_in,
	input  logic               rob_lbuffer_rst_in,

	// load buffer
	input  logic               mem_req,
	input  logic [`ADDR_W-1:0] mem_addr,
	input  load_op_e           mem_op,
	output logic               mem_done,
	output logic [31:0]        mem_data,

	// byte memory
	output logic               rd_en,
	output logic [`ADDR_W-1:0] rd_addr,
	input  logic [7:0]         rd_data
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_READ = 2'd1;
	localparam logic [1:0] S_WAIT = 2'd2;

	logic [1:0]         state;
	logic [1:0]         idx; // current byte lane
	logic [`ADDR_W-1:0] base_addr;
	load_op_e           op_q;
	byte_cnt_t          n_bytes;
	mem_word_u          word_q;
	mem_word_u          word_next;
	logic               last_byte;

	assign rd_en   = state == S_READ;
	assign rd_addr = base_addr + `ADDR_W'(idx);

	assign last_byte = (byte_cnt_t'(idx) + 3'd1) == n_bytes;

	// little endian, byte idx lands in lane idx
	always_comb begin
		word_next = word_q;
		word_next.lane[idx] = rd_data;
	end

	always_ff @(posedge clk_in) begin
		if (rob_lbuffer_rst_in) begin
			state    <= S_IDLE;
			idx      <= '0;
			mem_done <= 1'b0;
		end else begin
			mem_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (mem_req) begin
						state <= S_READ;
						idx   <= '0;
					end
				end
				S_READ: state <= S_WAIT; // rd_data back next cycle
				S_WAIT: begin
					if (last_byte) begin
						state    <= S_IDLE;
						mem_done <= 1'b1;
					end else begin
						state <= S_READ;
						idx   <= idx + 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// request and data payload
	always_ff @(posedge clk_in) begin
		if (state == S_IDLE && mem_req) begin
			base_addr <= mem_addr;
			op_q      <= mem_op;
			n_bytes   <= op_bytes(mem_op);
			word_q    <= '0;
		end else if (state == S_WAIT) begin
			word_q <= word_next;
		end
		if (state == S_WAIT && last_byte)
			mem_data <= extend_load(word_next, op_q);
	end

endmodule : data_ctrl

//--- source/load_buffer.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module load_buffer
	import load_pkg::*;
(
	input  logic                clk_in,
	input  logic                rob_lbuffer_rst_in,

	// address unit
	input  logic                load_valid,
	input  logic [`ADDR_W-1:0]  load_addr,
	input  logic [`ROB_W-1:0]   load_tag,
	input  load_op_e            load_op,
	output logic                load_ready,

	// reorder buffer
	output logic                head_valid,
	output logic [`ROB_W-1:0]   head_tag,
	input  logic                no_alias,
	input  logic                fwd_en,
	input  logic [31:0]         fwd_data,
	output logic                result_valid,
	output logic [`ROB_W-1:0]   result_tag,
	output logic [31:0]         result_data,

	// data controller
	output logic                mem_req,
	output logic [`ADDR_W-1:0]  mem_addr,
	output load_op_e            mem_op,
	input  logic                mem_done,
	input  logic [31:0]         mem_data
);

	localparam logic [1:0] IDLE    = 2'd0;
	localparam logic [1:0] PENDING = 2'd1;
	localparam logic [1:0] BUSY    = 2'd2;
	localparam logic [1:0] OK      = 2'd3;

	logic [`ADDR_W-1:0]  addr_q [`LB_COUNT];
	logic [`ROB_W-1:0]   tag_q  [`LB_COUNT];
	load_op_e            op_q   [`LB_COUNT];

	logic [`LB_PTR_W-1:0] head;
	logic [`LB_PTR_W-1:0] tail;
	logic [`LB_PTR_W:0]   count;
	logic [1:0]           stage;

	logic push;
	logic pop;
	logic fwd_hit;
	logic mem_hit;

	assign load_ready = count != `LB_COUNT;
	assign head_valid = count != 0;
	assign head_tag   = tag_q[head];

	assign push = load_valid && load_ready;

	// decisions only count while the head waits in IDLE, no_alias first
	assign fwd_hit = (stage == IDLE) && head_valid && !no_alias && fwd_en;
	assign mem_hit = (stage == BUSY) && mem_done;
	assign pop     = fwd_hit || mem_hit;

	assign result_valid = stage == OK;

	assign mem_req  = stage == PENDING; // one cycle only
	assign mem_addr = addr_q[head];
	assign mem_op   = op_q[head];

	// entry payload
	always_ff @(posedge clk_in) begin
		if (push) begin
			addr_q[tail] <= load_addr;
			tag_q[tail]  <= load_tag;
			op_q[tail]   <= load_op;
		end
	end

	// queue pointers
	always_ff @(posedge clk_in) begin
		if (rob_lbuffer_rst_in) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (push)
				tail <= tail + 1'b1; // wraps, depth is a power of two
			if (pop)
				head <= head + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// head stage machine
	always_ff @(posedge clk_in) begin
		if (rob_lbuffer_rst_in) begin
			stage <= IDLE;
		end else begin
			case (stage)
				IDLE: begin
					if (head_valid) begin
						if (no_alias)
							stage <= PENDING;
						else if (fwd_en)
							stage <= OK; // forwarded, memory skipped
					end
				end
				PENDING: stage <= BUSY;
				BUSY: begin
					if (mem_done)
						stage <= OK;
				end
				default: stage <= IDLE;
			endcase
		end
	end

	// result payload, shown while in OK
	always_ff @(posedge clk_in) begin
		if (pop)
			result_tag <= tag_q[head];
		if (fwd_hit)
			result_data <= extend_load(fwd_data, op_q[head]);
		else if (mem_hit)
			result_data <= mem_data; // already extended by the controller
	end

endmodule : load_buffer

//--- source/load_unit.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module load_unit
	import load_pkg::*;
(
	input  logic               clk_in,
	input  logic               rob_lbuffer_rst_in,

	// address unit
	input  logic               load_valid,
	input  logic [`ADDR_W-1:0] load_addr,
	input  logic [`ROB_W-1:0]  load_tag,
	input  load_op_e           load_op,
	output logic               load_ready,

	// reorder buffer
	input  logic               no_alias,
	input  logic               fwd_en,
	input  logic [31:0]        fwd_data,
	output logic               head_valid,
	output logic [`ROB_W-1:0]  head_tag,
	output logic               result_valid,
	output logic [`ROB_W-1:0]  result_tag,
	output logic [31:0]        result_data,

	// memory preload
	input  logic               wr_en,
	input  logic [`ADDR_W-1:0] wr_addr,
	input  logic [7:0]         wr_data
);

	logic               mem_req;
	logic [`ADDR_W-1:0] mem_addr;
	load_op_e           mem_op;
	logic               mem_done;
	logic [31:0]        mem_data;
	logic               rd_en;
	logic [`ADDR_W-1:0] rd_addr;
	logic [7:0]         rd_data;

	load_buffer load_buffer_i (
		.clk_in             (clk_in),
		.rob_lbuffer_rst_in (rob_lbuffer_rst_in),
		.load_valid         (load_valid),
		.load_addr          (load_addr),
		.load_tag           (load_tag),
		.load_op            (load_op),
		.load_ready         (load_ready),
		.head_valid         (head_valid),
		.head_tag           (head_tag),
		.no_alias           (no_alias),
		.fwd_en             (fwd_en),
		.fwd_data           (fwd_data),
		.result_valid       (result_valid),
		.result_tag         (result_tag),
		.result_data        (result_data),
		.mem_req            (mem_req),
		.mem_addr           (mem_addr),
		.mem_op             (mem_op),
		.mem_done           (mem_done),
		.mem_data           (mem_data)
	);

	data_ctrl data_ctrl_i (
		.clk_in             (clk_in),
		.rob_lbuffer_rst_in (rob_lbuffer_rst_in),
		.mem_req            (mem_req),
		.mem_addr           (mem_addr),
		.mem_op             (mem_op),
		.mem_done           (mem_done),
		.mem_data           (mem_data),
		.rd_en              (rd_en),
		.rd_addr            (rd_addr),
		.rd_data            (rd_data)
	);

	byte_ram byte_ram_i (
		.clk_in  (clk_in),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

endmodule : load_unit

//--- sim/load_unit_props.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module load_unit_props
	import load_pkg::*;
(
	input logic               clk_in,
	input logic               rob_lbuffer_rst_in,
	input logic               load_valid,
	input logic               load_ready,
	input logic [`ADDR_W-1:0] load_addr,
	input logic [`ROB_W-1:0]  load_tag,
	input load_op_e           load_op,
	input logic               result_valid,
	input logic               mem_req,
	input logic               mem_done,
	input logic               rd_en
);

	int   assert_fails = 0;
	logic req_open; // controller serving a request

	always_ff @(posedge clk_in) begin
		if (rob_lbuffer_rst_in)
			req_open <= 1'b0;
		else if (mem_req)
			req_open <= 1'b1;
		else if (mem_done)
			req_open <= 1'b0;
	end

	hold_load: assert property (@(posedge clk_in) disable iff (rob_lbuffer_rst_in)
		load_valid && !load_ready |=> load_valid && $stable(load_addr)
			&& $stable(load_tag) && $stable(load_op))
		else begin
			$error("load dropped or changed while stalled");
			assert_fails++;
		end

	result_pulse: assert property (@(posedge clk_in) disable iff (rob_lbuffer_rst_in)
		result_valid |=> !result_valid)
		else begin
			$error("result_valid held longer than one cycle");
			assert_fails++;
		end

	read_after_req: assert property (@(posedge clk_in) disable iff (rob_lbuffer_rst_in)
		rd_en |-> req_open)
		else begin
			$error("memory read without a request");
			assert_fails++;
		end

	quiet_after_reset: assert property (@(posedge clk_in)
		rob_lbuffer_rst_in |=> !result_valid && !mem_req && !mem_done && !rd_en && load_ready)
		else begin
			$error("activity in the cycle after reset");
			assert_fails++;
		end

endmodule : load_unit_props

bind load_unit load_unit_props load_unit_props_i (.*);

//--- sim/tb_load_unit.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module tb_load_unit
	import mem_pkg::*;
	import load_pkg::*;
();

	localparam int TIMEOUT = 1000; // cycles per wait

	logic               clk_in;
	logic               rob_lbuffer_rst_in;
	logic               load_valid;
	logic [`ADDR_W-1:0] load_addr;
	logic [`ROB_W-1:0]  load_tag;
	load_op_e           load_op;
	logic               load_ready;
	logic               no_alias;
	logic               fwd_en;
	logic [31:0]        fwd_data;
	logic               head_valid;
	logic [`ROB_W-1:0]  head_tag;
	logic               result_valid;
	logic [`ROB_W-1:0]  result_tag;
	logic [31:0]        result_data;
	logic               wr_en;
	logic [`ADDR_W-1:0] wr_addr;
	logic [7:0]         wr_data;

	logic [7:0]         shadow       [`MEM_DEPTH];
	logic               fwd_tab_en   [1 << `ROB_W]; // decision per tag
	logic [31:0]        fwd_tab_data [1 << `ROB_W];
	logic [`ROB_W+31:0] exp_q [$];                  // {tag, data} in issue order
	logic [`ROB_W+31:0] exp_head;
	logic [`ROB_W-1:0]  next_tag;
	logic               hold_decisions;
	integer             seed = 32'h679597ac;
	int                 errors, checks, tests, failed_tests, test_err_start;
	string              cur_test;
	event               run_end;
	load_op_e           op_list [5] = '{LB, LH, LW, LBU, LHU};

	load_unit load_unit_i (.*);

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;
	end

	// little endian word from the shadow bytes or the forwarded data, then extend
	function automatic logic [31:0] expected_result(input logic [`ADDR_W-1:0] addr,
		input load_op_e op, input logic fwd, input logic [31:0] fdata);
		logic [31:0] w;
		int          i;
		w = fdata;
		if (!fwd)
			for (i = 0; i < 4; i++)
				w[8*i +: 8] = shadow[addr + `ADDR_W'(i)];
		case (op)
			LB:      return {{24{w[7]}}, w[7:0]};
			LH:      return {{16{w[15]}}, w[15:0]};
			LBU:     return {24'd0, w[7:0]};
			LHU:     return {16'd0, w[15:0]};
			default: return w;
		endcase
	endfunction

	function automatic logic [`ADDR_W-1:0] rand_addr();
		return `ADDR_W'($random(seed));
	endfunction

	function automatic load_op_e rand_op();
		return op_list[$unsigned($random(seed)) % 5];
	endfunction

	task automatic check(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("** Error %s: %s expected %h actual %h", cur_test, what, expected, actual);
		end
	endtask

	task automatic timed_out(input string what);
		errors++;
		$display("%s: gave up waiting for %s", cur_test, what);
		-> run_end;
		@(posedge clk_in);
	endtask

	task automatic start_test(input string name);
		cur_test       = name;
		test_err_start = errors;
		tests++;
	endtask

	task automatic end_test();
		if (errors == test_err_start) begin
			$display("test %s: ok", cur_test);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", cur_test, errors - test_err_start);
		end
	endtask

	task automatic write_byte(input logic [`ADDR_W-1:0] addr, input logic [7:0] data);
		wr_en        = 1'b1;
		wr_addr      = addr;
		wr_data      = data;
		shadow[addr] = data;
		@(posedge clk_in);
		#1;
		wr_en = 1'b0;
	endtask

	// called 1 ns after a rising edge, returns at the same phase
	task automatic issue_load(input logic [`ADDR_W-1:0] addr, input load_op_e op,
		input logic fwd, input logic [31:0] fdata);
		int waited;
		fwd_tab_en[next_tag]   = fwd;
		fwd_tab_data[next_tag] = fdata;
		load_valid = 1'b1;
		load_addr  = addr;
		load_tag   = next_tag;
		load_op    = op;
		waited     = 0;
		@(negedge clk_in);
		while (!load_ready && waited < TIMEOUT) begin
			@(negedge clk_in);
			waited++;
		end
		if (!load_ready) begin
			timed_out("load_ready");
		end else begin
			@(posedge clk_in); // taken here
			exp_q.push_back({next_tag, expected_result(addr, op, fwd, fdata)});
			next_tag++;
			#1;
			load_valid = 1'b0;
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < TIMEOUT) begin
			@(negedge clk_in);
			waited++;
		end
		if (exp_q.size() != 0)
			timed_out("the outstanding results");
		@(posedge clk_in);
		#1;
		check("head_valid after drain", 32'd0, head_valid);
	endtask

	// plays the reorder buffer's alias decision for whatever sits at the head
	always @(posedge clk_in) begin
		#1;
		no_alias = 1'b0;
		fwd_en   = 1'b0;
		fwd_data = '0;
		if (head_valid && !hold_decisions && !rob_lbuffer_rst_in) begin
			if (fwd_tab_en[head_tag]) begin
				fwd_en   = 1'b1;
				fwd_data = fwd_tab_data[head_tag];
			end else begin
				no_alias = 1'b1;
			end
		end
	end

	always @(negedge clk_in) begin
		if (result_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("%s: result for tag %0d with no load outstanding", cur_test, result_tag);
			end else begin
				exp_head = exp_q.pop_front();
				check("result_tag", exp_head[`ROB_W+31:32], result_tag);
				check("result_data", exp_head[31:0], result_data);
			end
		end
		// head is the oldest load not yet answered
		if (head_valid && exp_q.size() != 0) begin
			exp_head = exp_q[0];
			check("head_tag", exp_head[`ROB_W+31:32], head_tag);
		end
	end

	initial begin
		@(run_end);
		errors = errors + load_unit_i.load_unit_props_i.assert_fails;
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		int                 i;
		int                 waited;
		logic [`ADDR_W-1:0] a;
		rob_lbuffer_rst_in = 1'b1;
		load_valid     = 1'b0;
		load_addr      = '0;
		load_tag       = '0;
		load_op        = LB;
		no_alias       = 1'b0;
		fwd_en         = 1'b0;
		fwd_data       = '0;
		wr_en          = 1'b0;
		wr_addr        = '0;
		wr_data        = '0;
		hold_decisions = 1'b0;
		next_tag       = '0;
		errors         = 0;
		checks         = 0;
		tests          = 0;
		failed_tests   = 0;
		repeat (4) @(posedge clk_in);
		#1;
		rob_lbuffer_rst_in = 1'b0;

		start_test("reset");
		check("load_ready", 32'd1, load_ready);
		check("result_valid", 32'd0, result_valid);
		for (i = 0; i < `MEM_DEPTH; i++)
			write_byte(i, 8'($random(seed)) ^ 8'(i) ^ 8'(i >> 8));
		end_test();

		start_test("memory_ops");
		a = rand_addr();
		write_byte(a, 8'h9c); // negative byte
		write_byte(a + 1'b1, 8'hf1); // and negative half
		for (i = 0; i < 5; i++)
			issue_load(a, op_list[i], 1'b0, '0);
		for (i = 0; i < 40; i++)
			issue_load(rand_addr(), rand_op(), 1'b0, '0);
		drain();
		end_test();

		start_test("forwarding");
		for (i = 0; i < 10; i++)
			issue_load(rand_addr(), op_list[i % 5], 1'b1, $random(seed) | (i[0] ? 32'h8080 : 0));
		drain();
		end_test();

		start_test("ordered_mix");
		for (i = 0; i < 40; i++)
			issue_load(rand_addr(), rand_op(), 1'($random(seed)), $random(seed));
		drain();
		end_test();

		start_test("back_pressure");
		hold_decisions = 1'b1;
		for (i = 0; i < `LB_COUNT; i++)
			issue_load(rand_addr(), rand_op(), i[0], $random(seed));
		@(negedge clk_in);
		check("load_ready when full", 32'd0, load_ready);
		@(posedge clk_in);
		#1;
		fork
			issue_load(rand_addr(), LW, 1'b0, '0);
			begin
				repeat (5) @(posedge clk_in);
				hold_decisions = 1'b0;
			end
		join
		drain();
		end_test();

		start_test("flush");
		for (i = 0; i < 4; i++)
			issue_load(rand_addr(), LW, 1'b0, '0);
		waited = 0;
		while (!load_unit_i.rd_en && waited < TIMEOUT) begin
			@(negedge clk_in);
			waited++;
		end
		if (!load_unit_i.rd_en)
			timed_out("a memory read");
		@(posedge clk_in);
		#1;
		rob_lbuffer_rst_in = 1'b1;
		exp_q.delete(); // queued loads are gone
		repeat (2) @(posedge clk_in);
		#1;
		rob_lbuffer_rst_in = 1'b0;
		@(negedge clk_in);
		check("load_ready after flush", 32'd1, load_ready);
		check("head_valid after flush", 32'd0, head_valid);
		repeat (20) @(negedge clk_in); // stray results show up in the compare
		@(posedge clk_in);
		#1;
		for (i = 0; i < 6; i++)
			issue_load(rand_addr(), rand_op(), 1'($random(seed)), $random(seed));
		drain();
		end_test();

		-> run_end;
	end

endmodule : tb_load_unit

//--- src.f
+incdir+source
source/mem_pkg.sv
source/load_pkg.sv
source/byte_ram.sv
source/data_ctrl.sv
source/load_buffer.sv
source/load_unit.sv
sim/load_unit_props.sv
sim/tb_load_unit.sv

//--- Bender.yml
package:
  name: load_unit

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/mem_pkg.sv
      - source/load_pkg.sv
      - source/byte_ram.sv
      - source/data_ctrl.sv
      - source/load_buffer.sv
      - source/load_unit.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/load_unit_props.sv
      - sim/tb_load_unit.sv
